//--- run_sim.sh
#!/usr/bin/env bash
# build the scratchpad testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module scratch_tb -f sources.f \
	--Mdir obj_dir -o scratch_sim \
	|| { echo "verilator build failed"; exit 1; }

./obj_dir/scratch_sim | tee /dev/stderr | grep -x "TB PASSED" > /dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

//--- sim/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
	input logic reset_req,
	output logic clk,
	output logic resetn
);
	localparam int HALF_PERIOD = 50;
	localparam int RESET_CYCLES = 2;

	logic por; // power-on reset, active high like resetn

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	initial begin
		por = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#10;
		por = 1'b0;
	end

	assign resetn = por || reset_req; // reset_req gives a reset in mid run

endmodule

`default_nettype wire

//--- sim/scratch_sva.sv
`timescale 1ns/1ps
`default_nettype none
`include "scratch_macros.svh"

module scratch_sva (
	input logic clk,
	input logic resetn,
	input logic rd_fire,
	input logic rsp_valid,
	input logic rsp_ready,
	input scratch_pkg::word_t rsp_rdata,
	input scratch_pkg::credit_t credit
);
	import scratch_pkg::*;

	localparam int DEPTH = `SCRATCH_RSP_DEPTH;

	int fail_count = 0;

	// queue plus in-flight reads never pass the depth
	credit_bound: assert property (@(posedge clk) disable iff (resetn)
		credit <= credit_t'(DEPTH))
	else begin
		$error("credit count above the response queue depth");
		fail_count++;
	end

	rsp_hold: assert property (@(posedge clk) disable iff (resetn)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata))
	else begin
		$error("response dropped or changed before its transfer");
		fail_count++;
	end

	no_read_when_full: assert property (@(posedge clk) disable iff (resetn)
		credit == credit_t'(DEPTH) |-> !rd_fire)
	else begin
		$error("read accepted with no free response slot");
		fail_count++;
	end

endmodule

bind scratch_port scratch_sva sva_i (
	.clk(clk),
	.resetn(resetn),
	.rd_fire(rd_fire),
	.rsp_valid(rsp_valid),
	.rsp_ready(rsp_ready),
	.rsp_rdata(rsp_rdata),
	.credit(credit)
);

`default_nettype wire

//--- sim/scratch_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "scratch_macros.svh"

module scratch_tb;
	import scratch_pkg::*;

	localparam int NUM_WORDS = 2 ** `SCRATCH_ADDR_WIDTH;
	localparam int BW = `SCRATCH_BYTE_WIDTH;
	localparam int LANES = `SCRATCH_DATA_WIDTH / BW;
	localparam int DEPTH = `SCRATCH_RSP_DEPTH;
	localparam int LATENCY = `SCRATCH_READ_LATENCY;
	localparam int DRIVE_DELAY = 10;
	localparam int NUM_WRITES = 48;
	localparam int NUM_RANDOM = 150;
	localparam int NUM_TXN = 6 * NUM_WORDS + NUM_WRITES + 2 * NUM_RANDOM + 7;

	logic clk;
	logic resetn;
	logic reset_req;
	logic a_req_valid;
	logic a_req_ready;
	logic a_req_write;
	addr_t a_req_addr;
	strobe_t a_req_strobe;
	word_t a_req_wdata;
	logic a_rsp_valid;
	logic a_rsp_ready;
	word_t a_rsp_rdata;
	logic b_req_valid;
	logic b_req_ready;
	addr_t b_req_addr;
	logic b_rsp_valid;
	logic b_rsp_ready;
	word_t b_rsp_rdata;

	word_t model [NUM_WORDS]; // mirror of the scratchpad
	word_t exp_a [$];
	word_t exp_b [$];
	int credit_a = 0;
	int credit_b = 0;
	int full_seen = 0;
	int checks = 0;
	int mismatches = 0;
	int other_errors = 0;
	int sva_fails = 0;
	bit stim_done;

	clk_gen clk_gen_i (
		.reset_req(reset_req),
		.clk(clk),
		.resetn(resetn)
	);

	scratch_top scratch_top_i (
		.clk(clk),
		.resetn(resetn),
		.a_req_valid(a_req_valid),
		.a_req_ready(a_req_ready),
		.a_req_write(a_req_write),
		.a_req_addr(a_req_addr),
		.a_req_strobe(a_req_strobe),
		.a_req_wdata(a_req_wdata),
		.a_rsp_valid(a_rsp_valid),
		.a_rsp_ready(a_rsp_ready),
		.a_rsp_rdata(a_rsp_rdata),
		.b_req_valid(b_req_valid),
		.b_req_ready(b_req_ready),
		.b_req_addr(b_req_addr),
		.b_rsp_valid(b_rsp_valid),
		.b_rsp_ready(b_rsp_ready),
		.b_rsp_rdata(b_rsp_rdata)
	);

	// strobed lanes take the new bytes and the rest keep the old word
	function automatic word_t merge_write(input word_t old_word, input word_t wdata,
			input strobe_t strobe);
		word_t result;
		result = old_word;
		for (int i = 0; i < LANES; i++) begin
			if (strobe[i]) begin
				result[i*BW +: BW] = wdata[i*BW +: BW];
			end
		end
		return result;
	endfunction

	task automatic check_value(input string name, input word_t expected, input word_t actual);
		checks++;
		if (expected !== actual) begin
			mismatches++;
			$display("MISMATCH %s expected %h actual %h", name, expected, actual);
		end
	endtask

	// starts at a drive point and returns at the drive point after the accept edge
	task automatic send_a(input logic is_write, input addr_t addr, input strobe_t strobe,
			input word_t wdata);
		logic accepted;
		a_req_valid = 1'b1;
		a_req_write = is_write;
		a_req_addr = addr;
		a_req_strobe = strobe;
		a_req_wdata = wdata;
		accepted = 1'b0;
		while (!accepted) begin
			@(negedge clk);
			accepted = a_req_ready;
			@(posedge clk);
			#DRIVE_DELAY;
		end
		a_req_valid = 1'b0;
		a_req_write = 1'b0;
	endtask

	task automatic send_b(input addr_t addr);
		logic accepted;
		b_req_valid = 1'b1;
		b_req_addr = addr;
		accepted = 1'b0;
		while (!accepted) begin
			@(negedge clk);
			accepted = b_req_ready;
			@(posedge clk);
			#DRIVE_DELAY;
		end
		b_req_valid = 1'b0;
	endtask

	task automatic drain();
		a_rsp_ready = 1'b1;
		b_rsp_ready = 1'b1;
		while (exp_a.size() != 0 || exp_b.size() != 0) begin
			@(posedge clk);
			#DRIVE_DELAY;
		end
	endtask

	task automatic read_all();
		fork
			begin
				for (int n = 0; n < NUM_WORDS; n++) begin
					send_a(1'b0, addr_t'(n), '0, '0);
				end
			end
			begin
				for (int n = 0; n < NUM_WORDS; n++) begin
					send_b(addr_t'(n));
				end
			end
		join
		drain();
	endtask

	task automatic random_a(input int count);
		for (int n = 0; n < count; n++) begin
			if ($urandom % 2 == 0) begin
				send_a(1'b1, addr_t'($urandom), strobe_t'($urandom), {$urandom, $urandom});
			end else begin
				send_a(1'b0, addr_t'($urandom), '0, '0);
			end
		end
	endtask

	task automatic random_b(input int count);
		for (int n = 0; n < count; n++) begin
			send_b(addr_t'($urandom));
		end
	endtask

	// counts negedges from the accept edge until rsp_valid shows up
	task automatic measure_latency(input bit use_b, input addr_t addr);
		int cycles;
		if (use_b) begin
			send_b(addr);
		end else begin
			send_a(1'b0, addr, '0, '0);
		end
		cycles = 0;
		@(negedge clk);
		while (!(use_b ? b_rsp_valid : a_rsp_valid) && cycles < 8) begin
			@(negedge clk);
			cycles++;
		end
		check_value(use_b ? "b_rsp_valid latency" : "a_rsp_valid latency",
			word_t'(LATENCY), word_t'(cycles));
		@(posedge clk);
		#DRIVE_DELAY;
		drain();
	endtask

	// inputs are stable at the negedge so this sees what the next edge transfers
	always @(negedge clk) begin
		if (resetn) begin
			for (int w = 0; w < NUM_WORDS; w++) begin
				model[w] = '0;
			end
			exp_a.delete();
			exp_b.delete();
			credit_a = 0;
			credit_b = 0;
		end else begin
			check_value("a_req_ready", word_t'(a_req_write || credit_a < DEPTH),
				word_t'(a_req_ready));
			check_value("b_req_ready", word_t'(credit_b < DEPTH), word_t'(b_req_ready));
			if ((a_req_valid && !a_req_write && credit_a == DEPTH) ||
					(b_req_valid && credit_b == DEPTH)) begin
				full_seen++;
			end
			if (a_rsp_valid && a_rsp_ready) begin
				if (exp_a.size() == 0) begin
					other_errors++;
					$display("port a gave a response with no read outstanding");
				end else begin
					check_value("a_rsp_rdata", exp_a.pop_front(), a_rsp_rdata);
				end
				credit_a--;
			end
			if (b_rsp_valid && b_rsp_ready) begin
				if (exp_b.size() == 0) begin
					other_errors++;
					$display("port b gave a response with no read outstanding");
				end else begin
					check_value("b_rsp_rdata", exp_b.pop_front(), b_rsp_rdata);
				end
				credit_b--;
			end
			// reads take the model before this cycle's write
			if (a_req_valid && a_req_ready && !a_req_write) begin
				exp_a.push_back(model[a_req_addr]);
				credit_a++;
			end
			if (b_req_valid && b_req_ready) begin
				exp_b.push_back(model[b_req_addr]);
				credit_b++;
			end
			if (a_req_valid && a_req_ready && a_req_write) begin
				model[a_req_addr] = merge_write(model[a_req_addr], a_req_wdata, a_req_strobe);
			end
		end
	end

	initial begin
		void'($urandom(11530));
		reset_req = 1'b0;
		a_req_valid = 1'b0;
		a_req_write = 1'b0;
		a_req_addr = '0;
		a_req_strobe = '0;
		a_req_wdata = '0;
		a_rsp_ready = 1'b1;
		b_req_valid = 1'b0;
		b_req_addr = '0;
		b_rsp_ready = 1'b1;
		stim_done = 1'b0;
		wait (!resetn);
		@(posedge clk);
		#DRIVE_DELAY;

		read_all(); // cleared by reset

		// full words first and then partial strobes over the same words
		for (int n = 0; n < NUM_WRITES; n++) begin
			if (n < 16) begin
				send_a(1'b1, addr_t'(n), '1, {$urandom, $urandom});
			end else begin
				send_a(1'b1, addr_t'($urandom % 16), strobe_t'($urandom), {$urandom, $urandom});
			end
		end
		read_all();

		fork
			send_a(1'b1, addr_t'(40), '1, 64'hfeed_0bad_c0de_5a5a);
			send_b(addr_t'(40)); // old word
		join
		send_b(addr_t'(40)); // new word
		drain();

		full_seen = 0;
		fork
			begin
				fork
					random_a(NUM_RANDOM);
					random_b(NUM_RANDOM);
				join
				stim_done = 1'b1;
			end
			while (!stim_done) begin
				a_rsp_ready = ($urandom % 3) == 0;
				b_rsp_ready = ($urandom % 3) == 0;
				@(posedge clk);
				#DRIVE_DELAY;
			end
		join
		drain();
		if (full_seen == 0) begin
			other_errors++;
			$display("read req_ready was never seen low with the credit count full");
		end

		measure_latency(1'b0, addr_t'(3));
		measure_latency(1'b1, addr_t'(3));

		// leave a response waiting on each port for the reset to clear
		a_rsp_ready = 1'b0;
		b_rsp_ready = 1'b0;
		fork
			send_a(1'b0, addr_t'(7), '0, '0);
			send_b(addr_t'(7));
		join
		repeat (LATENCY) begin
			@(posedge clk);
			#DRIVE_DELAY;
		end
		check_value("a_rsp_valid", word_t'(1), word_t'(a_rsp_valid));
		check_value("b_rsp_valid", word_t'(1), word_t'(b_rsp_valid));

		reset_req = 1'b1;
		repeat (2) @(posedge clk);
		#DRIVE_DELAY;
		reset_req = 1'b0;
		a_rsp_ready = 1'b1;
		b_rsp_ready = 1'b1;
		check_value("a_rsp_valid", '0, word_t'(a_rsp_valid));
		check_value("b_rsp_valid", '0, word_t'(b_rsp_valid));
		read_all();

		sva_fails = scratch_top_i.port_a.sva_i.fail_count + scratch_top_i.port_b.sva_i.fail_count;
		$display("checks %0d, mismatches %0d, other errors %0d, assertion failures %0d",
			checks, mismatches, other_errors, sva_fails);
		if (mismatches == 0 && other_errors == 0 && sva_fails == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	initial begin
		repeat (NUM_TXN * 20) @(posedge clk);
		$display("timeout, the run did not finish within %0d cycles", NUM_TXN * 20);
		$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
+incdir+verilog
verilog/scratch_pkg.sv
verilog/ram_port_if.sv
verilog/lutram_dualport.sv
verilog/scratch_port.sv
verilog/scratch_top.sv
sim/clk_gen.sv
sim/scratch_sva.sv
sim/scratch_tb.sv

//--- verilog/lutram_dualport.sv
`timescale 1ns/1ps
`default_nettype none
`include "scratch_macros.svh"

module lutram_dualport (
	input logic clk,
	input logic resetn,
	ram_port_if.ram p1,
	ram_port_if.ram p2
);
	import scratch_pkg::*;

	localparam int NUM_WORDS = 2 ** `SCRATCH_ADDR_WIDTH;
	localparam int BW = `SCRATCH_BYTE_WIDTH;
	localparam int LANES = `SCRATCH_DATA_WIDTH / BW;
	localparam int LATENCY = `SCRATCH_READ_LATENCY;

	// each word kept as byte lanes so strobes index it directly
	lane_t [LANES-1:0] mem [NUM_WORDS];

	logic rd_en [2];
	addr_t rd_addr [2];
	word_t rd_data [2];

	assign rd_en[0] = p1.en;
	assign rd_en[1] = p2.en;
	assign rd_addr[0] = p1.addr;
	assign rd_addr[1] = p2.addr;

	assign p1.rdata = rd_data[0];
	assign p2.rdata = rd_data[1];

	// write port is p1 only, p2 strobe and wdata never reach the array
	always_ff @(posedge clk) begin
		if (resetn) begin
			for (int w = 0; w < NUM_WORDS; w++) begin
				mem[w] <= '0;
			end
		end else if (p1.en) begin
			for (int i = 0; i < LANES; i++) begin
				if (p1.strobe[i]) begin
					mem[p1.addr][i] <= p1.wdata[i*BW +: BW];
				end
			end
		end
	end

	// nonblocking write above, so a same-edge read sees the old word
	for (genvar p = 0; p < 2; p++) begin : g_read
		if (LATENCY == 0) begin : g_comb
			assign rd_data[p] = mem[rd_addr[p]];
		end else begin : g_reg
			word_t stage [LATENCY];

			always_ff @(posedge clk) begin
				if (rd_en[p]) begin
					stage[0] <= mem[rd_addr[p]];
				end
				for (int s = 1; s < LATENCY; s++) begin
					stage[s] <= stage[s-1]; // later stages shift every cycle
				end
			end

			assign rd_data[p] = stage[LATENCY-1];
		end
	end

endmodule

`default_nettype wire

//--- verilog/ram_port_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ram_port_if;
	import scratch_pkg::*;

	logic en;        // access this cycle
	addr_t addr;
	strobe_t strobe; // zero on a read
	word_t wdata;
	word_t rdata;

	// request side, owned by the port logic
	modport ctrl (
		output en,
		output addr,
		output strobe,
		output wdata,
		input rdata
	);

	// memory side
	modport ram (
		input en,
		input addr,
		input strobe,
		input wdata,
		output rdata
	);

endinterface

`default_nettype wire

//--- verilog/scratch_macros.svh
`ifndef SCRATCH_MACROS_SVH
`define SCRATCH_MACROS_SVH

// 64 words of scratch storage
`define SCRATCH_ADDR_WIDTH 6

// one word holds eight byte lanes
`define SCRATCH_DATA_WIDTH 64
`define SCRATCH_BYTE_WIDTH 8

// register stages on each ram read port, 0 gives a combinational read
`define SCRATCH_READ_LATENCY 1

// response queue entries per port
`define SCRATCH_RSP_DEPTH 4

`endif

//--- verilog/scratch_pkg.sv
`default_nettype none
`include "scratch_macros.svh"

package scratch_pkg;

	// word address into the scratchpad
	typedef logic [`SCRATCH_ADDR_WIDTH-1:0] addr_t;

	typedef logic [`SCRATCH_DATA_WIDTH-1:0] word_t;

	// one bit per byte lane of a word
	typedef logic [`SCRATCH_DATA_WIDTH/`SCRATCH_BYTE_WIDTH-1:0] strobe_t;

	typedef logic [`SCRATCH_BYTE_WIDTH-1:0] lane_t;

	// in-flight reads plus queued responses, 0 up to the depth
	typedef logic [$clog2(`SCRATCH_RSP_DEPTH+1)-1:0] credit_t;

endpackage

`default_nettype wire

//--- verilog/scratch_port.sv
`timescale 1ns/1ps
`default_nettype none
`include "scratch_macros.svh"

module scratch_port #(
	parameter bit writable = 1'b1
) (
	input logic clk,
	input logic resetn,
	input logic req_valid,
	output logic req_ready,
	input logic req_write,
	input scratch_pkg::addr_t req_addr,
	input scratch_pkg::strobe_t req_strobe,
	input scratch_pkg::word_t req_wdata,
	output logic rsp_valid,
	input logic rsp_ready,
	output scratch_pkg::word_t rsp_rdata,
	ram_port_if.ctrl ram
);
	import scratch_pkg::*;

	localparam int DEPTH = `SCRATCH_RSP_DEPTH;
	localparam int LATENCY = `SCRATCH_READ_LATENCY;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic is_write;
	logic credit_full;
	logic req_fire;
	logic rd_fire;     // accepted read
	logic rsp_fire;
	logic rd_emerge;   // tracked read data valid at ram output
	credit_t credit;   // reads in flight plus queued responses
	credit_t q_count;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	word_t queue [DEPTH];

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(DEPTH - 1)) begin
			return '0;
		end
		return p + 1'b1;
	endfunction

	if (writable) begin : g_wr
		assign is_write = req_write;
		assign ram.strobe = req_write ? req_strobe : '0; // no lanes on a read
		assign ram.wdata = req_wdata;
	end else begin : g_ro
		assign is_write = 1'b0;
		assign ram.strobe = '0;
		assign ram.wdata = '0;
	end

	// writes never need a queue slot
	assign credit_full = (credit >= credit_t'(DEPTH));
	assign req_ready = is_write || !credit_full;

	assign req_fire = req_valid && req_ready;
	assign rd_fire = req_fire && !is_write;
	assign rsp_fire = rsp_valid && rsp_ready;

	// address goes out in the accept cycle
	assign ram.en = req_fire;
	assign ram.addr = req_addr;

	if (LATENCY == 0) begin : g_track_none
		assign rd_emerge = rd_fire;
	end else begin : g_track
		logic [LATENCY-1:0] track; // one bit per ram stage

		always_ff @(posedge clk) begin
			if (resetn) begin
				track <= '0;
			end else begin
				track[0] <= rd_fire;
				for (int i = 1; i < LATENCY; i++) begin
					track[i] <= track[i-1];
				end
			end
		end

		assign rd_emerge = track[LATENCY-1];
	end

	always_ff @(posedge clk) begin
		if (resetn) begin
			credit <= '0;
		end else begin
			case ({rd_fire, rsp_fire})
				2'b10: credit <= credit + credit_t'(1);
				2'b01: credit <= credit - credit_t'(1);
				default: ;
			endcase
		end
	end

	// response storage
	always_ff @(posedge clk) begin
		if (rd_emerge) begin
			queue[wr_ptr] <= ram.rdata;
		end
	end

	always_ff @(posedge clk) begin
		if (resetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			q_count <= '0;
		end else begin
			if (rd_emerge) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (rsp_fire) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({rd_emerge, rsp_fire})
				2'b10: q_count <= q_count + credit_t'(1);
				2'b01: q_count <= q_count - credit_t'(1);
				default: ;
			endcase
		end
	end

	assign rsp_valid = (q_count != '0);
	assign rsp_rdata = queue[rd_ptr];

endmodule

`default_nettype wire

//--- verilog/scratch_top.sv
`timescale 1ns/1ps
`default_nettype none

module scratch_top (
	input logic clk,
	input logic resetn,

	// port a, read and write
	input logic a_req_valid,
	output logic a_req_ready,
	input logic a_req_write,
	input scratch_pkg::addr_t a_req_addr,
	input scratch_pkg::strobe_t a_req_strobe,
	input scratch_pkg::word_t a_req_wdata,
	output logic a_rsp_valid,
	input logic a_rsp_ready,
	output scratch_pkg::word_t a_rsp_rdata,

	// port b, read only
	input logic b_req_valid,
	output logic b_req_ready,
	input scratch_pkg::addr_t b_req_addr,
	output logic b_rsp_valid,
	input logic b_rsp_ready,
	output scratch_pkg::word_t b_rsp_rdata
);

	ram_port_if ram_a ();
	ram_port_if ram_b (); // strobe and wdata tied off in port_b

	scratch_port #(
		.writable(1'b1)
	) port_a (
		.clk(clk),
		.resetn(resetn),
		.req_valid(a_req_valid),
		.req_ready(a_req_ready),
		.req_write(a_req_write),
		.req_addr(a_req_addr),
		.req_strobe(a_req_strobe),
		.req_wdata(a_req_wdata),
		.rsp_valid(a_rsp_valid),
		.rsp_ready(a_rsp_ready),
		.rsp_rdata(a_rsp_rdata),
		.ram(ram_a)
	);

	// write side of the port is not built here
	scratch_port #(
		.writable(1'b0)
	) port_b (
		.clk(clk),
		.resetn(resetn),
		.req_valid(b_req_valid),
		.req_ready(b_req_ready),
		.req_write(),
		.req_addr(b_req_addr),
		.req_strobe(),
		.req_wdata(),
		.rsp_valid(b_rsp_valid),
		.rsp_ready(b_rsp_ready),
		.rsp_rdata(b_rsp_rdata),
		.ram(ram_b)
	);

	lutram_dualport ram (
		.clk(clk),
		.resetn(resetn),
		.p1(ram_a),
		.p2(ram_b)
	);

endmodule

`default_nettype wire
